// File: src.f
+incdir+test
verilog/alu_pkg.sv
verilog/mul_pkg.sv
verilog/alu.sv
verilog/booth_encoder.sv
verilog/csa_layer.sv
verilog/pipe_reg.sv
verilog/exec_unit.sv
test/tb_exec_unit.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_exec_unit
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_exec_unit \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: test/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Expected result of one operation, worked out from the operation rules
function automatic logic [alu_pkg::XLEN-1:0] expected_result(
    input alu_pkg::exec_op_e        op,
    input logic [alu_pkg::XLEN-1:0] a,
    input logic [alu_pkg::XLEN-1:0] b
);
    logic [2*alu_pkg::XLEN-1:0] prod;
    logic [alu_pkg::XLEN-1:0]   fill;
    int                         sh;

    sh   = int'(b[alu_pkg::SHAMT_W-1:0]);
    fill = a[alu_pkg::XLEN-1] ? ~({alu_pkg::XLEN{1'b1}} >> sh) : '0;  // Copies of the sign bit
    prod = {{alu_pkg::XLEN{1'b0}}, a} * {{alu_pkg::XLEN{1'b0}}, b};  // Low half is sign-agnostic

    case (op)
        alu_pkg::OP_ADD: return a + b;
        alu_pkg::OP_SUB: return a + ~b + 1'b1;
        alu_pkg::OP_AND: return a & b;
        alu_pkg::OP_OR:  return a | b;
        alu_pkg::OP_XOR: return a ^ b;
        alu_pkg::OP_SLL: return a << sh;
        alu_pkg::OP_SRL: return a >> sh;
        alu_pkg::OP_SRA: return (a >> sh) | fill;
        alu_pkg::OP_SLT: begin
            // Differing signs decide by the sign of a
            if (a[alu_pkg::XLEN-1] != b[alu_pkg::XLEN-1]) begin
                return {{(alu_pkg::XLEN-1){1'b0}}, a[alu_pkg::XLEN-1]};
            end else begin
                return {{(alu_pkg::XLEN-1){1'b0}}, a < b};
            end
        end
        alu_pkg::OP_MUL: return prod[alu_pkg::XLEN-1:0];
        default:         return '0;
    endcase
endfunction

`endif

// File: test/tb_exec_unit.sv
`timescale 1ns/1ns

module tb_exec_unit;

    localparam int ALU_OPS   = 300;
    localparam int MUL_OPS   = 300;
    localparam int EDGE_OPS  = 25;   // Every pair of corner operands
    localparam int LAT_OPS   = 20;
    localparam int BP_OPS    = 400;
    localparam int TOTAL_OPS = ALU_OPS + MUL_OPS + EDGE_OPS + LAT_OPS + BP_OPS;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 3 + 16 + 200;

    logic                     clk = 1'b0;
    logic                     RST_n;
    logic                     in_valid;
    logic                     in_ready;
    alu_pkg::exec_op_e        in_op;
    logic [alu_pkg::XLEN-1:0] in_a;
    logic [alu_pkg::XLEN-1:0] in_b;
    logic                     out_valid;
    logic                     out_ready;
    logic [alu_pkg::XLEN-1:0] out_result;

    logic [alu_pkg::XLEN-1:0] exp_q[$];   // Scoreboard of expected results
    int                       acc_q[$];   // Acceptance cycle of each entry
    logic [alu_pkg::XLEN-1:0] corner_vals [5] = '{32'h0, 32'h1, 32'hffff_ffff,
                                                  32'h8000_0000, 32'h7fff_ffff};
    logic [alu_pkg::XLEN-1:0] held_result;
    int                       cycle;
    int                       errors;
    int                       tests_run;
    int                       tests_failed;
    int                       test_errors_start;
    bit                       rand_ready;
    bit                       check_latency;
    bit                       was_stall;

    `include "exec_model.svh"

    always #10 clk = ~clk;

    exec_unit i_dut (
        .clk        (clk),
        .RST_n      (RST_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    task automatic value_error(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic protocol_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors_start) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - test_errors_start);
            tests_failed++;
        end
        test_errors_start = errors;
    endtask

    task automatic drive_ready();
        out_ready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    endtask

    // Present one operation and wait for its transfer
    task automatic send(input logic [3:0] op_code, input logic [alu_pkg::XLEN-1:0] a,
                        input logic [alu_pkg::XLEN-1:0] b);
        @(negedge clk);
        in_valid = 1'b1;
        in_op    = alu_pkg::exec_op_e'(op_code);
        in_a     = a;
        in_b     = b;
        drive_ready();
        @(posedge clk);
        while (!in_ready) begin
            @(negedge clk);
            drive_ready();
            @(posedge clk);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
            drive_ready();
        end
    endtask

    task automatic drain();
        rand_ready = 1'b0;
        @(negedge clk);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // Scoreboard and protocol monitor, sampled on the rising edge
    always @(posedge clk) begin
        logic [alu_pkg::XLEN-1:0] exp_val;
        int                       acc_cycle;

        cycle++;
        if (!RST_n) begin
            was_stall = 1'b0;
        end else begin
            if (in_ready !== !(out_valid && !out_ready)) begin
                protocol_error("in_ready does not match the stall condition");
            end
            if (was_stall && out_result !== held_result) begin
                value_error($sformatf("out_result changed in a stall, %08h to %08h",
                                      held_result, out_result));
            end
            was_stall   = out_valid && !out_ready;
            held_result = out_result;

            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    protocol_error("a result came out with no operation pending");
                end else begin
                    exp_val   = exp_q.pop_front();
                    acc_cycle = acc_q.pop_front();
                    if (out_result !== exp_val) begin
                        value_error($sformatf("result %08h, expected %08h",
                                              out_result, exp_val));
                    end
                    if (check_latency && cycle - acc_cycle != 3) begin
                        value_error($sformatf("latency %0d cycles, expected 3",
                                              cycle - acc_cycle));
                    end
                end
            end

            if (in_valid && in_ready) begin
                exp_q.push_back(expected_result(in_op, in_a, in_b));
                acc_q.push_back(cycle);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("Watchdog expired: the run did not finish in the expected time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(68));
        RST_n         = 1'b0;
        in_valid      = 1'b0;
        in_op         = alu_pkg::OP_ADD;
        in_a          = '0;
        in_b          = '0;
        out_ready     = 1'b1;
        rand_ready    = 1'b0;
        check_latency = 1'b0;

        repeat (16) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
                protocol_error("out_valid or in_ready wrong during reset");
            end
        end
        RST_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
                protocol_error("out_valid or in_ready wrong after reset");
            end
        end
        end_test("reset");

        repeat (ALU_OPS) send(4'($urandom_range(0, 8)), $urandom, $urandom);
        drain();
        end_test("alu");

        repeat (MUL_OPS) send(4'(alu_pkg::OP_MUL), $urandom, $urandom);
        foreach (corner_vals[i]) begin
            foreach (corner_vals[j]) send(4'(alu_pkg::OP_MUL), corner_vals[i], corner_vals[j]);
        end
        drain();
        end_test("multiply");

        check_latency = 1'b1;  // Isolated operations only
        repeat (LAT_OPS) begin
            send(4'($urandom_range(0, 9)), $urandom, $urandom);
            idle(6);
        end
        drain();
        check_latency = 1'b0;
        end_test("latency");

        rand_ready = 1'b1;
        repeat (BP_OPS) begin
            send(4'($urandom_range(0, 9)), $urandom, $urandom);
            if ($urandom_range(0, 3) == 0) idle(1 + int'($urandom_range(0, 2)));
        end
        drain();
        idle(4);
        if (exp_q.size() != 0 || out_valid !== 1'b0) begin
            protocol_error("results still pending after the back-pressure drain");
        end
        end_test("backpressure");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic                       clk,
    input  logic                       RST_n,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  alu_pkg::exec_op_e          in_op,
    input  logic [alu_pkg::XLEN-1:0]   in_a,
    input  logic [alu_pkg::XLEN-1:0]   in_b,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [alu_pkg::XLEN-1:0]   out_result
);

    logic stall;

    // Stage 1 signals
    logic [alu_pkg::XLEN-1:0] alu_res;
    mul_pkg::pp_rows_t        pp_rows;
    mul_pkg::row_t [10:0]     l1_rows;   // 16 -> 11
    mul_pkg::s1_rows_t        l2_rows;   // 11 -> 8
    mul_pkg::s1_payload_t     s1_d;
    mul_pkg::s1_payload_t     s1_q;
    logic                     s1_valid;

    // Stage 2 signals
    mul_pkg::row_t [5:0]      l3_rows;   // 8 -> 6
    mul_pkg::s2_rows_t        l4_rows;   // 6 -> 4
    mul_pkg::s2_payload_t     s2_d;
    mul_pkg::s2_payload_t     s2_q;
    logic                     s2_valid;

    // Last stage signals
    mul_pkg::row_t [2:0]      l5_rows;   // 4 -> 3
    mul_pkg::row_t [1:0]      l6_rows;   // 3 -> 2
    logic [alu_pkg::XLEN-1:0] product;
    mul_pkg::out_payload_t    out_d;
    mul_pkg::out_payload_t    out_q;

    // Whole pipe freezes while the output is blocked
    assign stall    = out_valid && !out_ready;
    assign in_ready = !stall;

    alu i_alu (.op(in_op), .a(in_a), .b(in_b), .result(alu_res));

    booth_encoder i_booth (.a(in_a), .b(in_b), .rows(pp_rows));

    csa_layer #(.ROWS_IN(16)) i_csa_l1 (.rows_in(pp_rows), .rows_out(l1_rows));
    csa_layer #(.ROWS_IN(11)) i_csa_l2 (.rows_in(l1_rows), .rows_out(l2_rows));

    assign s1_d = '{op: in_op, alu_res: alu_res, rows: l2_rows};

    pipe_reg #(.payload_t(mul_pkg::s1_payload_t)) i_s1_reg (
        .clk     (clk),
        .RST_n   (RST_n),
        .stall   (stall),
        .d_valid (in_valid),
        .d       (s1_d),
        .q_valid (s1_valid),
        .q       (s1_q)
    );

    csa_layer #(.ROWS_IN(8)) i_csa_l3 (.rows_in(s1_q.rows), .rows_out(l3_rows));
    csa_layer #(.ROWS_IN(6)) i_csa_l4 (.rows_in(l3_rows), .rows_out(l4_rows));

    assign s2_d = '{op: s1_q.op, alu_res: s1_q.alu_res, rows: l4_rows};

    pipe_reg #(.payload_t(mul_pkg::s2_payload_t)) i_s2_reg (
        .clk     (clk),
        .RST_n   (RST_n),
        .stall   (stall),
        .d_valid (s1_valid),
        .d       (s2_d),
        .q_valid (s2_valid),
        .q       (s2_q)
    );

    csa_layer #(.ROWS_IN(4)) i_csa_l5 (.rows_in(s2_q.rows), .rows_out(l5_rows));
    csa_layer #(.ROWS_IN(3)) i_csa_l6 (.rows_in(l5_rows), .rows_out(l6_rows));

    assign product = l6_rows[0] + l6_rows[1];  // Carry-propagate add, low half only

    assign out_d.result = (s2_q.op == alu_pkg::OP_MUL) ? product : s2_q.alu_res;

    pipe_reg #(.payload_t(mul_pkg::out_payload_t)) i_out_reg (
        .clk     (clk),
        .RST_n   (RST_n),
        .stall   (stall),
        .d_valid (s2_valid),
        .d       (out_d),
        .q_valid (out_valid),
        .q       (out_q)
    );

    assign out_result = out_q.result;

    a_legal_op: assert property (@(posedge clk) disable iff (!RST_n)
        in_valid && in_ready |-> in_op <= alu_pkg::OP_MUL);

    // Held result must survive until the consumer takes it
    a_result_hold: assert property (@(posedge clk) disable iff (!RST_n)
        stall |=> $stable(out_result));

endmodule

// File: verilog/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     RST_n,
    input  logic     stall,
    input  logic     d_valid,
    input  payload_t d,
    output logic     q_valid,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            q_valid <= 1'b0;
        end else if (!stall) begin
            q_valid <= d_valid;  // Bubbles move too
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            q <= d;
        end
    end

    a_valid_known: assert property (@(posedge clk) RST_n |-> !$isunknown(q_valid));

    a_hold_valid: assert property (@(posedge clk) disable iff (!RST_n)
        stall |=> $stable(q_valid));

    a_hold_data: assert property (@(posedge clk) disable iff (!RST_n)
        stall && q_valid |=> $stable(q));

endmodule

// File: verilog/csa_layer.sv
`timescale 1ns/1ns

module csa_layer #(
    parameter  int ROWS_IN  = 3,
    localparam int ROWS_OUT = (ROWS_IN / 3) * 2 + ROWS_IN % 3
) (
    input  mul_pkg::row_t [ROWS_IN-1:0]   rows_in,
    output mul_pkg::row_t [ROWS_OUT-1:0]  rows_out
);

    localparam int GROUPS = ROWS_IN / 3;
    localparam int REST   = ROWS_IN % 3;

    // Full-adder columns, three rows in and two out
    for (genvar g = 0; g < GROUPS; g++) begin : g_csa
        mul_pkg::row_t x;
        mul_pkg::row_t y;
        mul_pkg::row_t z;
        mul_pkg::row_t carry;

        assign x = rows_in[3*g];
        assign y = rows_in[3*g+1];
        assign z = rows_in[3*g+2];

        assign carry = (x & y) | (x & z) | (y & z);

        assign rows_out[2*g]   = x ^ y ^ z;
        assign rows_out[2*g+1] = carry << 1;  // Top carry bit is beyond XLEN
    end

    // Rows that do not fill a group
    for (genvar r = 0; r < REST; r++) begin : g_pass
        assign rows_out[2*GROUPS+r] = rows_in[3*GROUPS+r];
    end

endmodule

// File: verilog/booth_encoder.sv
`timescale 1ns/1ns

module booth_encoder (
    input  logic [alu_pkg::XLEN-1:0]   a,
    input  logic [alu_pkg::XLEN-1:0]   b,
    output mul_pkg::pp_rows_t          rows
);

    // Multiplier with the implied zero below bit 0
    logic [alu_pkg::XLEN:0] b_ext;

    assign b_ext = {b, 1'b0};

    always_comb begin
        logic [2:0]    grp;
        mul_pkg::row_t pp;

        for (int i = 0; i < mul_pkg::PP_ROWS; i++) begin
            grp = b_ext[2*i +: 3];  // Overlapping triplet b[2i+1:2i-1]
            case (grp)
                3'b001, 3'b010: pp = a;
                3'b011:         pp = a << 1;
                3'b100:         pp = ~(a << 1) + 1'b1;  // -2a
                3'b101, 3'b110: pp = ~a + 1'b1;         // -a
                default:        pp = '0;
            endcase

            // Weight 4^i, bits above XLEN fall away
            rows[i] = pp << (2 * i);
        end
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns

module alu (
    input  alu_pkg::exec_op_e          op,
    input  logic [alu_pkg::XLEN-1:0]   a,
    input  logic [alu_pkg::XLEN-1:0]   b,
    output logic [alu_pkg::XLEN-1:0]   result
);

    logic [alu_pkg::SHAMT_W-1:0] shamt;
    logic                        less;

    assign shamt = b[alu_pkg::SHAMT_W-1:0];
    assign less  = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_pkg::OP_ADD: result = a + b;
            alu_pkg::OP_SUB: result = a - b;
            alu_pkg::OP_AND: result = a & b;
            alu_pkg::OP_OR:  result = a | b;
            alu_pkg::OP_XOR: result = a ^ b;
            alu_pkg::OP_SLL: result = a << shamt;
            alu_pkg::OP_SRL: result = a >> shamt;
            alu_pkg::OP_SRA: result = $signed(a) >>> shamt;  // Sign fill
            alu_pkg::OP_SLT: result = {{(alu_pkg::XLEN-1){1'b0}}, less};
            default:         result = '0;  // Multiply result comes from the tree
        endcase
    end

endmodule

// File: verilog/mul_pkg.sv
package mul_pkg;

    localparam int PP_ROWS = 16;  // Radix-4 Booth rows for 32 bits
    localparam int S1_ROWS = 8;   // Rows held after stage 1
    localparam int S2_ROWS = 4;   // Rows held after stage 2

    // Only the low product bits are kept, so rows stay XLEN wide
    typedef logic [alu_pkg::XLEN-1:0] row_t;

    typedef row_t [PP_ROWS-1:0] pp_rows_t;
    typedef row_t [S1_ROWS-1:0] s1_rows_t;
    typedef row_t [S2_ROWS-1:0] s2_rows_t;

    typedef struct packed {
        alu_pkg::exec_op_e          op;
        logic [alu_pkg::XLEN-1:0]   alu_res;
        s1_rows_t                   rows;
    } s1_payload_t;

    typedef struct packed {
        alu_pkg::exec_op_e          op;
        logic [alu_pkg::XLEN-1:0]   alu_res;
        s2_rows_t                   rows;
    } s2_payload_t;

    typedef struct packed {
        logic [alu_pkg::XLEN-1:0]   result;
    } out_payload_t;

endpackage

// File: verilog/alu_pkg.sv
package alu_pkg;

    localparam int XLEN    = 32;
    localparam int SHAMT_W = 5;  // Low bits of operand b used by shifts

    // Operation codes, 10 to 15 unused
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SLL = 4'd5,
        OP_SRL = 4'd6,
        OP_SRA = 4'd7,
        OP_SLT = 4'd8,  // Signed compare
        OP_MUL = 4'd9   // Low half of product
    } exec_op_e;

endpackage
